// ==== hw/oram_settings.svh ====
// Size parameters of the ORAM output stage, shared by packages and RTL
`ifndef ORAM_SETTINGS_SVH
`define ORAM_SETTINGS_SVH

// Parallel RAM lanes
`define ORAM_NUM_LANES 4

// RAM address width, 256 words per lane
`define ORAM_ADDR_W 8

// Word width, top bit is the sign for ReLU
`define ORAM_DATA_W 8

// Ingress FIFO depth as log2, 4 entries
`define ORAM_FIFO_AW 2

// Command code width
`define ORAM_CMD_W 8

`endif

// ==== hw/oram_mode_pkg.sv ====
// Operating modes of the ORAM stage and the one-hot command codes that select them
`default_nettype none

`include "oram_settings.svh"

package oram_mode_pkg;

    // Mode held by the controller and seen by every lane
    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_ZERO = 2'd1,
        MODE_CONV = 2'd2,
        MODE_READ = 2'd3
    } oram_mode_e;

    // One-hot command codes on the config channel
    localparam logic [`ORAM_CMD_W-1:0] CMD_ZERO = 8'h02;
    localparam logic [`ORAM_CMD_W-1:0] CMD_CONV = 8'h04;
    localparam logic [`ORAM_CMD_W-1:0] CMD_READ = 8'h20;

endpackage

`default_nettype wire

// ==== hw/oram_data_pkg.sv ====
// Data types carried through the ORAM stage
`default_nettype none

`include "oram_settings.svh"

package oram_data_pkg;

    typedef logic [`ORAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [`ORAM_DATA_W-1:0] ram_word_t;
    typedef logic [`ORAM_CMD_W-1:0]  cmd_word_t;

    // Ingress FIFO entry, packed as {last, address, data}
    typedef logic [`ORAM_ADDR_W+`ORAM_DATA_W:0] fifo_entry_t;

endpackage

`default_nettype wire

// ==== hw/oram_cmd_if.sv ====
// Command bus from the ORAM controller to the lanes and the done collector
`timescale 1ns/1ps
`default_nettype none

interface oram_cmd_if;

    oram_mode_pkg::oram_mode_e mode;
    logic                      relu_ena;
    logic                      start;
    logic                      all_done;

    modport ctrl (
        output mode,
        output relu_ena,
        output start,
        input  all_done
    );

    modport lane (
        input mode,
        input relu_ena,
        input start
    );

    modport collect (
        input  start,
        output all_done
    );

endinterface

`default_nettype wire

// ==== hw/oram_ctrl.sv ====
// ORAM command controller that captures a command and runs the mode FSM
`timescale 1ns/1ps
`default_nettype none

module oram_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cfg_vld_i,
    output logic                      cfg_rdy_o,
    input  oram_data_pkg::cmd_word_t  cfg_cmd_i,
    input  wire                       cfg_relu_i,
    output logic                      is_idle_o,
    oram_cmd_if.ctrl                  cmd
);

    oram_mode_pkg::oram_mode_e mode_q;
    oram_mode_pkg::oram_mode_e dec_mode;
    logic                      dec_known;
    logic                      relu_q;
    logic                      start_q;
    logic                      unk_q;
    logic                      cfg_ena;

    // Unknown code keeps the stage busy for exactly one cycle
    assign is_idle_o = (mode_q == oram_mode_pkg::MODE_IDLE) && !unk_q;
    assign cfg_rdy_o = is_idle_o;
    assign cfg_ena   = cfg_vld_i && cfg_rdy_o;

    always_comb begin
        dec_known = 1'b1;
        case (cfg_cmd_i)
            oram_mode_pkg::CMD_ZERO: dec_mode = oram_mode_pkg::MODE_ZERO;
            oram_mode_pkg::CMD_CONV: dec_mode = oram_mode_pkg::MODE_CONV;
            oram_mode_pkg::CMD_READ: dec_mode = oram_mode_pkg::MODE_READ;
            default: begin
                dec_mode  = oram_mode_pkg::MODE_IDLE;
                dec_known = 1'b0;
            end
        endcase
    end

    // ==================================================
    // Mode FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q  <= oram_mode_pkg::MODE_IDLE;
            relu_q  <= 1'b0;
            start_q <= 1'b0;
            unk_q   <= 1'b0;
        end else begin
            start_q <= cfg_ena && dec_known;
            unk_q   <= cfg_ena && !dec_known;
            if (cfg_ena) begin
                mode_q <= dec_mode;
                relu_q <= cfg_relu_i;
            end else if (mode_q != oram_mode_pkg::MODE_IDLE && cmd.all_done && !start_q) begin
                // Flags still hold the previous run during the start cycle
                mode_q <= oram_mode_pkg::MODE_IDLE;
            end
        end
    end

    assign cmd.mode     = mode_q;
    assign cmd.relu_ena = relu_q;
    assign cmd.start    = start_q;

    // ==================================================
    // Assertions
    // ==================================================
    a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(mode_q) && (mode_q inside {oram_mode_pkg::MODE_IDLE,
            oram_mode_pkg::MODE_ZERO, oram_mode_pkg::MODE_CONV, oram_mode_pkg::MODE_READ}));

endmodule

`default_nettype wire

// ==== hw/oram_lane.sv ====
// One ORAM lane with ingress FIFO, zero fill, ReLU write select, RAM array and read port
`timescale 1ns/1ps
`default_nettype none

`include "oram_settings.svh"

module oram_lane (
    input  wire                       clk,
    input  wire                       rst_n,
    oram_cmd_if.lane                  cmd,
    // Write channel
    input  wire                       wr_vld_i,
    output logic                      wr_rdy_o,
    input  wire                       wr_lst_i,
    input  oram_data_pkg::ram_addr_t  wr_addr_i,
    input  oram_data_pkg::ram_word_t  wr_data_i,
    // Read-address channel
    input  wire                       rd_addr_vld_i,
    output logic                      rd_addr_rdy_o,
    input  wire                       rd_addr_lst_i,
    input  oram_data_pkg::ram_addr_t  rd_addr_i,
    // Read-data channel
    output logic                      rd_vld_o,
    input  wire                       rd_rdy_i,
    output logic                      rd_lst_o,
    output oram_data_pkg::ram_word_t  rd_data_o,
    output logic                      done_o
);

    localparam int FIFO_DEPTH = 1 << `ORAM_FIFO_AW;
    localparam int RAM_DEPTH  = 1 << `ORAM_ADDR_W;

    logic mode_zero;
    logic mode_conv;
    logic mode_read;

    assign mode_zero = (cmd.mode == oram_mode_pkg::MODE_ZERO);
    assign mode_conv = (cmd.mode == oram_mode_pkg::MODE_CONV);
    assign mode_read = (cmd.mode == oram_mode_pkg::MODE_READ);

    // ==================================================
    // Ingress FIFO
    // ==================================================
    oram_data_pkg::fifo_entry_t fifo_mem [FIFO_DEPTH];
    logic [`ORAM_FIFO_AW:0]     wr_ptr_q;
    logic [`ORAM_FIFO_AW:0]     rd_ptr_q;
    logic                       fifo_full;
    logic                       fifo_empty;
    logic                       fifo_push;
    logic                       fifo_pop;
    oram_data_pkg::fifo_entry_t fifo_head;
    logic                       head_lst;
    oram_data_pkg::ram_addr_t   head_addr;
    oram_data_pkg::ram_word_t   head_data;

    assign fifo_empty = (wr_ptr_q == rd_ptr_q);
    assign fifo_full  = (wr_ptr_q[`ORAM_FIFO_AW] != rd_ptr_q[`ORAM_FIFO_AW]) &&
                        (wr_ptr_q[`ORAM_FIFO_AW-1:0] == rd_ptr_q[`ORAM_FIFO_AW-1:0]);

    assign wr_rdy_o  = mode_conv && !fifo_full;
    assign fifo_push = wr_vld_i && wr_rdy_o;
    // Head drains straight into the RAM
    assign fifo_pop  = mode_conv && !fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr_q[`ORAM_FIFO_AW-1:0]] <= {wr_lst_i, wr_addr_i, wr_data_i};
        end
    end

    assign fifo_head = fifo_mem[rd_ptr_q[`ORAM_FIFO_AW-1:0]];
    assign head_lst  = fifo_head[`ORAM_ADDR_W+`ORAM_DATA_W];
    assign head_addr = fifo_head[`ORAM_DATA_W +: `ORAM_ADDR_W];
    assign head_data = fifo_head[`ORAM_DATA_W-1:0];

    // ==================================================
    // Zero fill
    // ==================================================
    oram_data_pkg::ram_addr_t zero_cnt_q;
    logic                     zero_fin_q;
    logic                     zero_act;
    logic                     zero_last;

    // A new start reopens the fill even if the last one finished
    assign zero_act  = mode_zero && (cmd.start || !zero_fin_q);
    assign zero_last = zero_act && (zero_cnt_q == '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_cnt_q <= '0;
            zero_fin_q <= 1'b0;
        end else begin
            if (zero_act) begin
                zero_cnt_q <= zero_cnt_q + 1'b1;
            end
            if (zero_last) begin
                zero_fin_q <= 1'b1;
            end else if (cmd.start) begin
                zero_fin_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // Write select and RAM
    // ==================================================
    logic                     ram_we;
    oram_data_pkg::ram_addr_t ram_waddr;
    oram_data_pkg::ram_word_t ram_wdata;
    oram_data_pkg::ram_word_t ram [RAM_DEPTH];

    always_comb begin
        ram_we    = 1'b0;
        ram_waddr = zero_cnt_q;
        ram_wdata = '0;
        if (zero_act) begin
            ram_we = 1'b1;
        end else if (fifo_pop) begin
            ram_we    = 1'b1;
            ram_waddr = head_addr;
            // ReLU clamps negative words
            ram_wdata = (cmd.relu_ena && head_data[`ORAM_DATA_W-1]) ? '0 : head_data;
        end
    end

    // ==================================================
    // Read port
    // ==================================================
    logic rd_vld_q;
    logic rd_lst_q;
    logic rd_addr_ena;
    logic rd_out_ena;

    assign rd_addr_rdy_o = mode_read && (!rd_vld_q || rd_rdy_i);
    assign rd_addr_ena   = rd_addr_vld_i && rd_addr_rdy_o;
    assign rd_out_ena    = rd_vld_q && rd_rdy_i;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_waddr] <= ram_wdata;
        end
        if (rd_addr_ena) begin
            rd_data_o <= ram[rd_addr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
            rd_lst_q <= 1'b0;
        end else if (rd_addr_ena) begin
            rd_vld_q <= 1'b1;
            rd_lst_q <= rd_addr_lst_i;
        end else if (rd_out_ena) begin
            rd_vld_q <= 1'b0;
            rd_lst_q <= 1'b0;
        end
    end

    assign rd_vld_o = rd_vld_q;
    assign rd_lst_o = rd_lst_q;

    // One pulse per function, whichever mode is running
    assign done_o = zero_last || (fifo_pop && head_lst) || (rd_out_ena && rd_lst_q);

    // ==================================================
    // Assertions
    // ==================================================
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full |-> !fifo_push);

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld_o && !rd_rdy_i |=> rd_vld_o && $stable(rd_data_o) && $stable(rd_lst_o));

endmodule

`default_nettype wire

// ==== hw/oram_done_collect.sv ====
// Collects per-lane done pulses into sticky flags and reports when all lanes are done
`timescale 1ns/1ps
`default_nettype none

`include "oram_settings.svh"

module oram_done_collect (
    input  wire                         clk,
    input  wire                         rst_n,
    oram_cmd_if.collect                 cmd,
    input  wire [`ORAM_NUM_LANES-1:0]   lane_done_i
);

    logic [`ORAM_NUM_LANES-1:0] done_q;

    // Start wipes the flags of the previous run, a pulse sets its lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            done_q <= (done_q & ~{`ORAM_NUM_LANES{cmd.start}}) | lane_done_i;
        end
    end

    assign cmd.all_done = &done_q;

endmodule

`default_nettype wire

// ==== hw/oram_top.sv ====
// Top level of the ORAM output stage with the controller, the lane array and the done collector
`timescale 1ns/1ps
`default_nettype none

`include "oram_settings.svh"

module oram_top (
    input  wire                                               clk,
    input  wire                                               rst_n,
    output logic                                              is_idle_o,
    // Config channel
    input  wire                                               cfg_vld_i,
    output logic                                              cfg_rdy_o,
    input  oram_data_pkg::cmd_word_t                          cfg_cmd_i,
    input  wire                                               cfg_relu_i,
    // Write channel per lane
    input  wire  [`ORAM_NUM_LANES-1:0]                        wr_vld_i,
    output logic [`ORAM_NUM_LANES-1:0]                        wr_rdy_o,
    input  wire  [`ORAM_NUM_LANES-1:0]                        wr_lst_i,
    input  oram_data_pkg::ram_addr_t [`ORAM_NUM_LANES-1:0]    wr_addr_i,
    input  oram_data_pkg::ram_word_t [`ORAM_NUM_LANES-1:0]    wr_data_i,
    // Read-address channel per lane
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_addr_vld_i,
    output logic [`ORAM_NUM_LANES-1:0]                        rd_addr_rdy_o,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_addr_lst_i,
    input  oram_data_pkg::ram_addr_t [`ORAM_NUM_LANES-1:0]    rd_addr_i,
    // Read-data channel per lane
    output logic [`ORAM_NUM_LANES-1:0]                        rd_vld_o,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_rdy_i,
    output logic [`ORAM_NUM_LANES-1:0]                        rd_lst_o,
    output oram_data_pkg::ram_word_t [`ORAM_NUM_LANES-1:0]    rd_data_o
);

    oram_cmd_if cmd_bus ();

    logic [`ORAM_NUM_LANES-1:0] lane_done;

    oram_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_vld_i  (cfg_vld_i),
        .cfg_rdy_o  (cfg_rdy_o),
        .cfg_cmd_i  (cfg_cmd_i),
        .cfg_relu_i (cfg_relu_i),
        .is_idle_o  (is_idle_o),
        .cmd        (cmd_bus)
    );

    // ==================================================
    // Lane array
    // ==================================================
    for (genvar i = 0; i < `ORAM_NUM_LANES; i++) begin : g_lane
        oram_lane u_lane (
            .clk           (clk),
            .rst_n         (rst_n),
            .cmd           (cmd_bus),
            .wr_vld_i      (wr_vld_i[i]),
            .wr_rdy_o      (wr_rdy_o[i]),
            .wr_lst_i      (wr_lst_i[i]),
            .wr_addr_i     (wr_addr_i[i]),
            .wr_data_i     (wr_data_i[i]),
            .rd_addr_vld_i (rd_addr_vld_i[i]),
            .rd_addr_rdy_o (rd_addr_rdy_o[i]),
            .rd_addr_lst_i (rd_addr_lst_i[i]),
            .rd_addr_i     (rd_addr_i[i]),
            .rd_vld_o      (rd_vld_o[i]),
            .rd_rdy_i      (rd_rdy_i[i]),
            .rd_lst_o      (rd_lst_o[i]),
            .rd_data_o     (rd_data_o[i]),
            .done_o        (lane_done[i])
        );
    end

    oram_done_collect u_done_collect (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd_bus),
        .lane_done_i (lane_done)
    );

endmodule

`default_nettype wire

// ==== verif/oram_checker.sv ====
// Checker for the ORAM stage that follows the read channels and compares words with the model
`timescale 1ns/1ps
`default_nettype none

`include "oram_settings.svh"

module oram_checker (
    input  wire                                               clk,
    input  wire                                               rst_n,
    input  wire  [8*16-1:0]                                   test_name_i,
    input  oram_data_pkg::ram_word_t                          ref_mem_i [`ORAM_NUM_LANES]
                                                                        [1 << `ORAM_ADDR_W],
    input  wire                                               idle_i,
    input  wire                                               cfg_rdy_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        wr_rdy_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_addr_vld_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_addr_rdy_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_addr_lst_i,
    input  oram_data_pkg::ram_addr_t [`ORAM_NUM_LANES-1:0]    rd_addr_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_vld_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_rdy_i,
    input  wire  [`ORAM_NUM_LANES-1:0]                        rd_lst_i,
    input  oram_data_pkg::ram_word_t [`ORAM_NUM_LANES-1:0]    rd_data_i,
    output int                                                err_cnt_o
);

    localparam int NL = `ORAM_NUM_LANES;

    // Expected {last, word} per lane, in request order
    logic [`ORAM_DATA_W:0] exp_q [NL][$];
    logic [`ORAM_DATA_W:0] exp;
    logic                  idle_q = 1'b1;
    int                    errs = 0;

    assign err_cnt_o = errs;

    always @(posedge clk) begin
        if (rst_n) begin
            if (cfg_rdy_i !== idle_i) begin
                $display("MISMATCH %0s cfg_rdy_o: expected %0b, actual %0b",
                         test_name_i, idle_i, cfg_rdy_i);
                errs++;
            end
            if (idle_i && ((wr_rdy_i | rd_addr_rdy_i | rd_vld_i) != '0)) begin
                $display("Error in %0s: a channel ready or valid is high while the stage is idle",
                         test_name_i);
                errs++;
            end
            for (int l = 0; l < NL; l++) begin
                // Older word leaves before a new request joins the queue
                if (rd_vld_i[l] && rd_rdy_i[l]) begin
                    if (exp_q[l].size() == 0) begin
                        $display("Error in %0s: lane %0d returned a word that was never requested",
                                 test_name_i, l);
                        errs++;
                    end else begin
                        exp = exp_q[l].pop_front();
                        if ({rd_lst_i[l], rd_data_i[l]} !== exp) begin
                            $display({"MISMATCH %0s lane %0d: expected lst=%0b data=%02h, ",
                                      "actual lst=%0b data=%02h"}, test_name_i, l,
                                     exp[`ORAM_DATA_W], exp[`ORAM_DATA_W-1:0],
                                     rd_lst_i[l], rd_data_i[l]);
                            errs++;
                        end
                    end
                end
                if (rd_addr_vld_i[l] && rd_addr_rdy_i[l]) begin
                    exp_q[l].push_back({rd_addr_lst_i[l], ref_mem_i[l][rd_addr_i[l]]});
                end
                // Back to idle means every requested word came out
                if (idle_i && !idle_q && exp_q[l].size() != 0) begin
                    $display("Error in %0s: lane %0d went idle with %0d words never returned",
                             test_name_i, l, exp_q[l].size());
                    errs++;
                    exp_q[l].delete();
                end
            end
            idle_q = idle_i;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_oram.sv ====
// Testbench for the ORAM output stage with stimulus tasks and a ReLU reference model
`timescale 1ns/1ps
`default_nettype none

`include "oram_settings.svh"

module tb_oram;

    localparam int NL      = `ORAM_NUM_LANES;
    localparam int DEPTH   = 1 << `ORAM_ADDR_W;
    localparam int TIMEOUT = 5000;

    logic                                             clk;
    logic                                             rst_n;
    logic                                             is_idle_o;
    logic                                             cfg_vld_i;
    logic                                             cfg_rdy_o;
    oram_data_pkg::cmd_word_t                         cfg_cmd_i;
    logic                                             cfg_relu_i;
    logic [NL-1:0]                                    wr_vld_i;
    logic [NL-1:0]                                    wr_rdy_o;
    logic [NL-1:0]                                    wr_lst_i;
    oram_data_pkg::ram_addr_t [NL-1:0]                wr_addr_i;
    oram_data_pkg::ram_word_t [NL-1:0]                wr_data_i;
    logic [NL-1:0]                                    rd_addr_vld_i;
    logic [NL-1:0]                                    rd_addr_rdy_o;
    logic [NL-1:0]                                    rd_addr_lst_i;
    oram_data_pkg::ram_addr_t [NL-1:0]                rd_addr_i;
    logic [NL-1:0]                                    rd_vld_o;
    logic [NL-1:0]                                    rd_rdy_i;
    logic [NL-1:0]                                    rd_lst_o;
    oram_data_pkg::ram_word_t [NL-1:0]                rd_data_o;

    // Reference memory of every lane
    oram_data_pkg::ram_word_t ref_mem [NL][DEPTH];
    logic [8*16-1:0]          test_name;
    int                       tb_errs;
    int                       chk_errs;

    always #5 clk = ~clk;

    oram_top DUT (.*);

    oram_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .test_name_i   (test_name),
        .ref_mem_i     (ref_mem),
        .idle_i        (is_idle_o),
        .cfg_rdy_i     (cfg_rdy_o),
        .wr_rdy_i      (wr_rdy_o),
        .rd_addr_vld_i (rd_addr_vld_i),
        .rd_addr_rdy_i (rd_addr_rdy_o),
        .rd_addr_lst_i (rd_addr_lst_i),
        .rd_addr_i     (rd_addr_i),
        .rd_vld_i      (rd_vld_o),
        .rd_rdy_i      (rd_rdy_i),
        .rd_lst_i      (rd_lst_o),
        .rd_data_i     (rd_data_o),
        .err_cnt_o     (chk_errs)
    );

    // ==================================================
    // Reference model and helpers
    // ==================================================
    // Negative words are stored as zero when ReLU is on
    function automatic oram_data_pkg::ram_word_t ref_word(input oram_data_pkg::ram_word_t data,
                                                          input logic relu);
        if (relu && data[`ORAM_DATA_W-1]) begin
            return '0;
        end
        return data;
    endfunction

    function automatic bit beats_pending(input int idx [NL], input int n);
        foreach (idx[l]) begin
            if (idx[l] < n) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_reset_state();
        if (!is_idle_o || !cfg_rdy_o || ((wr_rdy_o | rd_addr_rdy_o | rd_vld_o) != '0)) begin
            $display("Error in reset: idle, ready or valid outputs not at their reset values");
            tb_errs++;
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        @(negedge clk);
        while (!is_idle_o && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!is_idle_o) begin
            $display("Timeout in %0s: the stage did not return to idle", test_name);
            tb_errs++;
        end
    endtask

    task automatic send_cmd(input oram_data_pkg::cmd_word_t code, input logic relu);
        int t;
        t = 0;
        @(negedge clk);
        while (!cfg_rdy_o && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!cfg_rdy_o) begin
            $display("Timeout in %0s: the config channel never became ready", test_name);
            tb_errs++;
        end else begin
            cfg_vld_i  = 1'b1;
            cfg_cmd_i  = code;
            cfg_relu_i = relu;
            @(negedge clk);
            cfg_vld_i  = 1'b0;
        end
    endtask

    // ==================================================
    // Channel drivers
    // ==================================================
    task automatic conv_write(input int n, input logic relu);
        int            idx [NL];
        int            guard;
        logic [NL-1:0] taken;
        send_cmd(oram_mode_pkg::CMD_CONV, relu);
        foreach (idx[l]) begin
            idx[l] = 0;
        end
        taken = '0;
        guard = 0;
        while (beats_pending(idx, n) && guard < TIMEOUT) begin
            @(negedge clk);
            wr_vld_i = wr_vld_i & ~taken;
            taken    = '0;
            for (int l = 0; l < NL; l++) begin
                if (!wr_vld_i[l] && idx[l] < n) begin
                    wr_vld_i[l]  = 1'b1;
                    wr_lst_i[l]  = (idx[l] == n - 1);
                    // Narrow address range so that some addresses are written twice
                    wr_addr_i[l] = oram_data_pkg::ram_addr_t'($urandom % 64);
                    wr_data_i[l] = oram_data_pkg::ram_word_t'($urandom);
                end
            end
            #1;
            for (int l = 0; l < NL; l++) begin
                if (wr_vld_i[l] && wr_rdy_o[l]) begin
                    ref_mem[l][wr_addr_i[l]] = ref_word(wr_data_i[l], relu);
                    taken[l] = 1'b1;
                    idx[l]++;
                end
            end
            guard++;
        end
        if (beats_pending(idx, n)) begin
            $display("Timeout in %0s: write beats were not accepted", test_name);
            tb_errs++;
        end
        @(negedge clk);
        wr_vld_i = '0;
        wait_idle();
    endtask

    task automatic read_mem(input int n, input bit seq, input bit bp);
        int            idx [NL];
        int            guard;
        logic [NL-1:0] taken;
        send_cmd(oram_mode_pkg::CMD_READ, 1'b0);
        foreach (idx[l]) begin
            idx[l] = 0;
        end
        taken = '0;
        guard = 0;
        while (beats_pending(idx, n) && guard < TIMEOUT) begin
            @(negedge clk);
            rd_addr_vld_i = rd_addr_vld_i & ~taken;
            taken         = '0;
            for (int l = 0; l < NL; l++) begin
                if (!rd_addr_vld_i[l] && idx[l] < n) begin
                    rd_addr_vld_i[l] = 1'b1;
                    rd_addr_lst_i[l] = (idx[l] == n - 1);
                    if (seq) begin
                        rd_addr_i[l] = oram_data_pkg::ram_addr_t'(idx[l]);
                    end else begin
                        rd_addr_i[l] = oram_data_pkg::ram_addr_t'($urandom);
                    end
                end
            end
            if (bp) begin
                rd_rdy_i = NL'($urandom);
            end else begin
                rd_rdy_i = '1;
            end
            #1;
            for (int l = 0; l < NL; l++) begin
                if (rd_addr_vld_i[l] && rd_addr_rdy_o[l]) begin
                    taken[l] = 1'b1;
                    idx[l]++;
                end
            end
            guard++;
        end
        if (beats_pending(idx, n)) begin
            $display("Timeout in %0s: read addresses were not accepted", test_name);
            tb_errs++;
        end
        @(negedge clk);
        rd_addr_vld_i = '0;
        rd_rdy_i      = '1;
        wait_idle();
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        void'($urandom(72904));
        clk           = 1'b0;
        rst_n         = 1'b0;
        cfg_vld_i     = 1'b0;
        cfg_cmd_i     = '0;
        cfg_relu_i    = 1'b0;
        wr_vld_i      = '0;
        wr_lst_i      = '0;
        wr_addr_i     = '0;
        wr_data_i     = '0;
        rd_addr_vld_i = '0;
        rd_addr_lst_i = '0;
        rd_addr_i     = '0;
        rd_rdy_i      = '0;
        tb_errs       = 0;
        test_name     = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();

        test_name = "zero_read";
        send_cmd(oram_mode_pkg::CMD_ZERO, 1'b0);
        wait_idle();
        foreach (ref_mem[l, a]) begin
            ref_mem[l][a] = '0;
        end
        read_mem(DEPTH, 1'b1, 1'b0);

        test_name = "conv_relu_off";
        conv_write(200, 1'b0);
        read_mem(DEPTH, 1'b1, 1'b0);

        test_name = "conv_relu_on";
        conv_write(200, 1'b1);
        read_mem(DEPTH, 1'b1, 1'b0);

        test_name = "read_backpress";
        read_mem(300, 1'b0, 1'b1);

        // Unknown code with every channel offering a beat
        test_name = "unknown_cmd";
        @(negedge clk);
        wr_vld_i      = '1;
        rd_addr_vld_i = '1;
        rd_rdy_i      = '1;
        send_cmd(oram_data_pkg::cmd_word_t'(8'h11), 1'b0);
        for (int c = 0; c < 4; c++) begin
            if ((wr_rdy_o | rd_addr_rdy_o) != '0) begin
                $display("Error in %0s: a beat was accepted after an unknown command", test_name);
                tb_errs++;
            end
            @(negedge clk);
        end
        wait_idle();
        wr_vld_i      = '0;
        rd_addr_vld_i = '0;
        read_mem(DEPTH, 1'b1, 1'b0);

        @(negedge clk);
        $display("Errors: %0d (checker %0d, testbench %0d)", chk_errs + tb_errs, chk_errs, tb_errs);
        if (chk_errs + tb_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/oram_mode_pkg.sv
hw/oram_data_pkg.sv
hw/oram_cmd_if.sv
hw/oram_ctrl.sv
hw/oram_lane.sv
hw/oram_done_collect.sv
hw/oram_top.sv
verif/oram_checker.sv
verif/tb_oram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ORAM testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_oram \
    -o sim_oram > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_oram > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
